// ==== filelist.f ====
common/video_pkg.sv
common/regs_pkg.sv
capture/pixel_capture.sv
com/com_divider.sv
com/center_of_mass.sv
design/pixel_threshold.sv
design/view_mux.sv
design/apb_regs.sv
design/tracker_top.sv
tests/tracker_chk.sv
tests/tracker_tb.sv

// ==== Makefile ====
# Verilator flow for the colour tracker

VERILATOR ?= verilator
TOP       ?= tracker_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tracker_tb.sv ====
module tracker_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int frame_w      = 16;
  localparam int frame_h      = 8;
  localparam int phase_cycles = 4;   // clk cycles per pclk level
  localparam int line_gap     = 8;
  localparam int line_cycles  = 1 + phase_cycles + frame_w * 4 * phase_cycles + line_gap;
  localparam int frame_cycles = 1 + frame_h * line_cycles + 4 * phase_cycles;
  localparam int update_limit = 400;  // per wait for the frame counter
  localparam int frames_sent  = 7;
  localparam int cycle_limit  = frames_sent * (frame_cycles + update_limit) + 3000;

  logic               clk_65mhz, sys_rst;
  logic               cam_pclk, cam_vsync, cam_href;
  logic [7:0]         cam_data;
  regs_pkg::apb_req_t apb;
  regs_pkg::apb_rsp_t apb_rsp;
  video_pkg::view_t   view;

  video_pkg::pixel_565_t frame_mem [frame_h][frame_w];  // frame being sent
  logic [31:0]           lfsr = 32'hf184_c1ae;
  int                    mismatches, failures, assert_total, cycles, view_seen;
  logic                  view_check_on;
  string                 view_name;
  // model of the dut state, kept from what was written and predicted
  video_pkg::channel_e   cur_channel;
  video_pkg::view_e      cur_view;
  video_pkg::nibble_t    cur_lower, cur_upper;
  video_pkg::hcount_t    cur_com_x;
  video_pkg::vcount_t    cur_com_y;

  tracker_top tracker_top_inst (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .cam_pclk  (cam_pclk),
    .cam_vsync (cam_vsync),
    .cam_href  (cam_href),
    .cam_data  (cam_data),
    .apb       (apb),
    .apb_rsp   (apb_rsp),
    .view      (view)
  );

  bind apb_regs tracker_chk apb_chk_inst (
    .clk_65mhz (clk_65mhz), .sys_rst (sys_rst), .psel (apb.psel), .penable (apb.penable),
    .pready (apb_rsp.pready), .com_update (1'b0), .com_x (video_pkg::hcount_t'(0))
  );
  bind center_of_mass tracker_chk com_chk_inst (
    .clk_65mhz (clk_65mhz), .sys_rst (sys_rst), .psel (1'b0), .penable (1'b0),
    .pready (1'b1), .com_update (com_update), .com_x (com_x)
  );

  initial begin
    clk_65mhz = 1'b0;
    forever #10 clk_65mhz = ~clk_65mhz;  // 50 MHz stand-in for the 65 MHz clock
  end

  always @(posedge clk_65mhz) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic video_pkg::pixel_565_t random_pixel();
    video_pkg::pixel_565_t p;
    p = '0;
    for (int i = 0; i < 16; i++) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      p    = {p[14:0], lfsr[0]};
    end
    return p;
  endfunction

  // top four bits of the chosen 565 component
  function automatic video_pkg::nibble_t channel_nibble(video_pkg::pixel_565_t p);
    case (cur_channel)
      video_pkg::ch_green: return p[10:7];
      video_pkg::ch_blue:  return p[4:1];
      default:             return p[15:12];
    endcase
  endfunction

  function automatic logic in_bounds(video_pkg::pixel_565_t p);
    return channel_nibble(p) >= cur_lower && channel_nibble(p) <= cur_upper;
  endfunction

  function automatic logic [31:0] com_word(video_pkg::hcount_t x, video_pkg::vcount_t y);
    return {6'b0, y, 5'b0, x};
  endfunction

  // floor averages of masked coordinates, old com on an empty frame
  function automatic logic [31:0] expected_com();
    int sx, sy, n;
    sx = 0;
    sy = 0;
    n  = 0;
    for (int v = 0; v < frame_h; v++)
      for (int h = 0; h < frame_w; h++)
        if (in_bounds(frame_mem[v][h])) begin
          sx += h;
          sy += v;
          n++;
        end
    if (n == 0)
      return com_word(cur_com_x, cur_com_y);
    return com_word(video_pkg::hcount_t'(sx / n), video_pkg::vcount_t'(sy / n));
  endfunction

  function automatic video_pkg::view_t expected_view(int h, int v);
    video_pkg::view_t      e;
    video_pkg::pixel_565_t p;
    video_pkg::pixel_444_t cam;
    p        = frame_mem[v][h];
    cam      = {p[15:12], p[10:7], p[4:1]};
    e.hcount = video_pkg::hcount_t'(h);
    e.vcount = video_pkg::vcount_t'(v);
    e.valid  = 1'b1;
    case (cur_view)
      video_pkg::view_mask:      e.pixel = in_bounds(p) ? 12'hfff : 12'h000;
      video_pkg::view_crosshair:
        e.pixel = (h == int'(cur_com_x) || v == int'(cur_com_y)) ? 12'h0f0 : cam;
      default:                   e.pixel = cam;
    endcase
    return e;
  endfunction

  task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_view(string name, video_pkg::view_t exp, video_pkg::view_t act);
    string exp_txt;
    if (act !== exp) begin
      mismatches++;
      exp_txt = $sformatf("pixel %h at (%0d,%0d) valid %b", exp.pixel, exp.hcount,
                          exp.vcount, exp.valid);
      $display("mismatch %s: expected %s, actual pixel %h at (%0d,%0d) valid %b", name,
               exp_txt, act.pixel, act.hcount, act.vcount, act.valid);
    end
  endtask

  task automatic wait_cycles(int n);
    repeat (n) @(posedge clk_65mhz);
  endtask

  // setup phase, access phase, then idle; sampled mid access phase
  task automatic apb_access(logic [3:0] addr, logic write, logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk_65mhz);
    apb.paddr   <= addr;
    apb.pwrite  <= write;
    apb.pwdata  <= wdata;
    apb.psel    <= 1'b1;
    apb.penable <= 1'b0;
    @(posedge clk_65mhz);
    apb.penable <= 1'b1;
    @(negedge clk_65mhz);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk_65mhz);  // write lands on this edge
    apb.psel    <= 1'b0;
    apb.penable <= 1'b0;
  endtask

  task automatic apb_write(logic [3:0] addr, logic [31:0] data, output logic err);
    logic [31:0] unused_rd;
    apb_access(addr, 1'b1, data, unused_rd, err);
  endtask

  task automatic apb_read(logic [3:0] addr, output logic [31:0] data, output logic err);
    apb_access(addr, 1'b0, 32'h0, data, err);
  endtask

  task automatic set_config(video_pkg::channel_e ch, video_pkg::view_e v,
                            video_pkg::nibble_t lo, video_pkg::nibble_t up);
    logic [31:0] data;
    logic        err;
    apb_write(regs_pkg::addr_ctrl, {26'b0, v, 2'b0, ch}, err);
    check_bit("ctrl write pslverr", 1'b0, err);
    apb_write(regs_pkg::addr_bounds, {24'b0, up, lo}, err);
    check_bit("bounds write pslverr", 1'b0, err);
    apb_read(regs_pkg::addr_ctrl, data, err);
    check_word("ctrl readback", {26'b0, v, 2'b0, ch}, data);
    apb_read(regs_pkg::addr_bounds, data, err);
    check_word("bounds readback", {24'b0, up, lo}, data);
    cur_channel = ch;
    cur_view    = v;
    cur_lower   = lo;
    cur_upper   = up;
  endtask

  task automatic fill_random();
    for (int v = 0; v < frame_h; v++)
      for (int h = 0; h < frame_w; h++)
        frame_mem[v][h] = random_pixel();
  endtask

  // one pclk period, byte taken on the rising edge
  task automatic pclk_cycle(logic [7:0] b);
    cam_data <= b;
    cam_pclk <= 1'b0;
    wait_cycles(phase_cycles);
    cam_pclk <= 1'b1;
    wait_cycles(phase_cycles);
  endtask

  task automatic send_frame();
    @(posedge clk_65mhz);
    for (int v = 0; v < frame_h; v++) begin
      cam_href <= 1'b1;
      wait_cycles(phase_cycles);
      for (int h = 0; h < frame_w; h++) begin
        pclk_cycle(frame_mem[v][h][15:8]);  // high byte first
        pclk_cycle(frame_mem[v][h][7:0]);
      end
      cam_href <= 1'b0;  // falling href moves to the next row
      wait_cycles(line_gap);
    end
    cam_vsync <= 1'b1;
    wait_cycles(2 * phase_cycles);
    cam_vsync <= 1'b0;
    wait_cycles(2 * phase_cycles);
  endtask

  task automatic wait_frame(logic [31:0] prev);
    logic [31:0] data;
    logic        err;
    int          waited;
    data   = prev;
    waited = 0;
    while (data == prev && waited < update_limit) begin
      apb_read(regs_pkg::addr_frames, data, err);
      waited += 3;
    end
    if (data == prev) begin
      failures++;
      $display("center of mass never updated");
    end
  endtask

  task automatic run_frame(string name);
    logic [31:0] frames0, exp_com, data;
    logic        err;
    apb_read(regs_pkg::addr_frames, frames0, err);
    exp_com = expected_com();
    send_frame();
    wait_frame(frames0);
    apb_read(regs_pkg::addr_com, data, err);
    check_word({name, " com"}, exp_com, data);
    apb_read(regs_pkg::addr_frames, data, err);
    check_word({name, " frame count"}, frames0 + 32'd1, data);
    cur_com_x = exp_com[10:0];
    cur_com_y = exp_com[25:16];
  endtask

  always @(negedge clk_65mhz) begin
    if (view_check_on && view.valid) begin
      view_seen++;
      if (int'(view.hcount) >= frame_w || int'(view.vcount) >= frame_h) begin
        failures++;
        $display("view pixel at (%0d,%0d) lies outside the sent frame",
                 view.hcount, view.vcount);
      end else begin
        check_view(view_name, expected_view(int'(view.hcount), int'(view.vcount)), view);
      end
    end
  end

  task automatic test_reset();
    logic [31:0] data;
    logic        err;
    apb_read(regs_pkg::addr_ctrl, data, err);
    check_word("reset ctrl", {26'b0, regs_pkg::cfg_reset.view, 2'b0,
                              regs_pkg::cfg_reset.channel}, data);
    check_bit("reset pslverr", 1'b0, err);
    apb_read(regs_pkg::addr_bounds, data, err);
    check_word("reset bounds", {24'b0, regs_pkg::cfg_reset.upper,
                                regs_pkg::cfg_reset.lower}, data);
    apb_read(regs_pkg::addr_com, data, err);
    check_word("reset com", 32'h0, data);
    apb_read(regs_pkg::addr_frames, data, err);
    check_word("reset frame count", 32'h0, data);
    repeat (20) begin
      @(negedge clk_65mhz);
      check_bit("reset view valid", 1'b0, view.valid);
    end
  endtask

  task automatic test_registers();
    logic [31:0] data;
    logic        err;
    set_config(video_pkg::ch_blue, video_pkg::view_mask, 4'h3, 4'hc);
    apb_write(regs_pkg::addr_ctrl, 32'hffff_ffe6, err);  // spare bits ignored
    apb_read(regs_pkg::addr_ctrl, data, err);
    check_word("ctrl field mask", 32'h22, data);
    apb_read(4'h2, data, err);  // hole in the map
    check_bit("unmapped read pslverr", 1'b1, err);
    check_word("unmapped read data", 32'h0, data);
    apb_write(4'h6, 32'hffff_ffff, err);
    check_bit("unmapped write pslverr", 1'b1, err);
    apb_write(regs_pkg::addr_com, 32'h0155_0155, err);
    check_bit("com write pslverr", 1'b1, err);
    apb_write(regs_pkg::addr_frames, 32'h0000_abcd, err);
    check_bit("frames write pslverr", 1'b1, err);
    apb_read(regs_pkg::addr_com, data, err);
    check_word("com after bad write", 32'h0, data);
    apb_read(regs_pkg::addr_frames, data, err);
    check_word("frames after bad write", 32'h0, data);
    apb_read(regs_pkg::addr_ctrl, data, err);
    check_word("ctrl after bad writes", 32'h22, data);
    apb_read(regs_pkg::addr_bounds, data, err);
    check_word("bounds after bad writes", 32'hc3, data);
    set_config(video_pkg::ch_red, video_pkg::view_camera, 4'h0, 4'hf);
  endtask

  task automatic test_channels();
    fill_random();
    set_config(video_pkg::ch_green, video_pkg::view_camera, 4'h4, 4'h9);
    run_frame("green");
    fill_random();
    set_config(video_pkg::ch_blue, video_pkg::view_camera, 4'ha, 4'he);
    run_frame("blue");
    set_config(video_pkg::ch_blue, video_pkg::view_camera, 4'hf, 4'h0);  // nothing passes
    run_frame("empty frame");
  endtask

  task automatic test_views();
    video_pkg::view_e modes [3];
    modes = '{video_pkg::view_camera, video_pkg::view_mask, video_pkg::view_crosshair};
    foreach (modes[i]) begin
      fill_random();
      // red, green, blue in turn so every channel sees narrow bounds
      set_config(video_pkg::channel_e'(i), modes[i], 4'h3, 4'hc);
      view_name     = modes[i].name();
      view_seen     = 0;
      view_check_on = 1'b1;
      run_frame(view_name);
      view_check_on = 1'b0;
      check_word({view_name, " pixel count"}, frame_w * frame_h, view_seen);
    end
  endtask

  initial begin
    sys_rst       = 1'b1;
    cam_pclk      = 1'b0;
    cam_vsync     = 1'b0;
    cam_href      = 1'b0;
    cam_data      = 8'h00;
    apb           = '0;
    view_check_on = 1'b0;
    cur_channel   = regs_pkg::cfg_reset.channel;
    cur_view      = regs_pkg::cfg_reset.view;
    cur_lower     = regs_pkg::cfg_reset.lower;
    cur_upper     = regs_pkg::cfg_reset.upper;
    cur_com_x     = '0;
    cur_com_y     = '0;
    wait_cycles(3);
    sys_rst <= 1'b0;
    wait_cycles(2);
    test_reset();
    test_registers();
    fill_random();
    run_frame("default red");
    test_channels();
    test_views();
    assert_total = tracker_top_inst.apb_regs_inst.apb_chk_inst.assert_errors
                 + tracker_top_inst.center_of_mass_inst.com_chk_inst.assert_errors;
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, assert_total);
    if (mismatches == 0 && failures == 0 && assert_total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== tests/tracker_chk.sv ====
module tracker_chk (
  input logic               clk_65mhz,
  input logic               sys_rst,
  input logic               psel,
  input logic               penable,
  input logic               pready,
  input logic               com_update,
  input video_pkg::hcount_t com_x
);

  timeunit 1ns;
  timeprecision 1ps;

  int assert_errors = 0;  // read back by the testbench at the end

  // zero wait states, every access phase completes at once
  pready_in_access: assert property (
    @(posedge clk_65mhz) disable iff (sys_rst) (psel && penable) |-> pready
  ) else begin
    $error("pready low in an apb access phase");
    assert_errors++;
  end

  // result strobe is a single cycle pulse
  com_update_pulse: assert property (
    @(posedge clk_65mhz) disable iff (sys_rst) com_update |=> !com_update
  ) else begin
    $error("com_update held for more than one cycle");
    assert_errors++;
  end

  com_x_in_frame: assert property (
    @(posedge clk_65mhz) disable iff (sys_rst) int'(com_x) < video_pkg::frame_width
  ) else begin
    $error("com_x outside the frame width");
    assert_errors++;
  end

endmodule

// ==== design/tracker_top.sv ====
module tracker_top (
  input  logic               clk_65mhz,
  input  logic               sys_rst,
  input  logic               cam_pclk,
  input  logic               cam_vsync,
  input  logic               cam_href,
  input  logic [7:0]         cam_data,
  input  regs_pkg::apb_req_t apb,
  output regs_pkg::apb_rsp_t apb_rsp,
  output video_pkg::view_t   view
);

  video_pkg::stream_t cap_pix;  // from the camera side
  video_pkg::stream_t thr_pix;  // aligned with thr_mask
  logic               thr_mask;
  video_pkg::hcount_t com_x;
  video_pkg::vcount_t com_y;
  logic               com_update;
  regs_pkg::cfg_t     cfg;

  pixel_capture pixel_capture_inst (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .cam_pclk  (cam_pclk),
    .cam_vsync (cam_vsync),
    .cam_href  (cam_href),
    .cam_data  (cam_data),
    .pix       (cap_pix)
  );

  pixel_threshold pixel_threshold_inst (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .pix       (cap_pix),
    .cfg       (cfg),
    .pix_out   (thr_pix),
    .mask      (thr_mask)
  );

  center_of_mass center_of_mass_inst (
    .clk_65mhz  (clk_65mhz),
    .sys_rst    (sys_rst),
    .pix        (thr_pix),
    .mask       (thr_mask),
    .com_x      (com_x),
    .com_y      (com_y),
    .com_update (com_update)
  );

  view_mux view_mux_inst (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .pix       (thr_pix),
    .mask      (thr_mask),
    .cfg       (cfg),
    .com_x     (com_x),
    .com_y     (com_y),
    .view      (view)
  );

  apb_regs apb_regs_inst (
    .clk_65mhz  (clk_65mhz),
    .sys_rst    (sys_rst),
    .apb        (apb),
    .apb_rsp    (apb_rsp),
    .com_x      (com_x),
    .com_y      (com_y),
    .com_update (com_update),
    .cfg        (cfg)
  );

endmodule

// ==== design/apb_regs.sv ====
module apb_regs (
  input  logic               clk_65mhz,
  input  logic               sys_rst,
  input  regs_pkg::apb_req_t apb,
  output regs_pkg::apb_rsp_t apb_rsp,
  input  video_pkg::hcount_t com_x,
  input  video_pkg::vcount_t com_y,
  input  logic               com_update,
  output regs_pkg::cfg_t     cfg
);

  logic        access;  // apb access phase
  logic [31:0] rdata;
  logic        err;
  logic [15:0] frames;

  assign access = apb.psel && apb.penable;

  // address decode, error covers unmapped and read-only writes
  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (apb.paddr)
      regs_pkg::addr_ctrl:   rdata = {26'b0, cfg.view, 2'b0, cfg.channel};
      regs_pkg::addr_bounds: rdata = {24'b0, cfg.upper, cfg.lower};
      regs_pkg::addr_com: begin
        err = apb.pwrite;
        if (!apb.pwrite)
          rdata = {6'b0, com_y, 5'b0, com_x};
      end
      regs_pkg::addr_frames: begin
        err = apb.pwrite;
        if (!apb.pwrite)
          rdata = {16'b0, frames};
      end
      default: err = 1'b1;
    endcase
  end

  assign apb_rsp.prdata  = access ? rdata : '0;
  assign apb_rsp.pready  = 1'b1;  // no wait states
  assign apb_rsp.pslverr = access && err;

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      cfg    <= regs_pkg::cfg_reset;
      frames <= '0;
    end else begin
      if (com_update)
        frames <= frames + 16'd1;  // one per finished frame
      if (access && apb.pwrite && !err) begin
        case (apb.paddr)
          regs_pkg::addr_ctrl: begin
            cfg.channel <= video_pkg::channel_e'(apb.pwdata[1:0]);
            cfg.view    <= video_pkg::view_e'(apb.pwdata[5:4]);
          end
          regs_pkg::addr_bounds: begin
            cfg.lower <= apb.pwdata[3:0];
            cfg.upper <= apb.pwdata[7:4];
          end
          default: ;  // read-only already flagged
        endcase
      end
    end
  end

endmodule

// ==== design/view_mux.sv ====
module view_mux (
  input  logic               clk_65mhz,
  input  logic               sys_rst,
  input  video_pkg::stream_t pix,
  input  logic               mask,
  input  regs_pkg::cfg_t     cfg,
  input  video_pkg::hcount_t com_x,
  input  video_pkg::vcount_t com_y,
  output video_pkg::view_t   view
);

  video_pkg::pixel_444_t cam_444, out_pixel;
  logic                  on_cross;

  assign cam_444  = {pix.pixel[15:12], pix.pixel[10:7], pix.pixel[4:1]};
  assign on_cross = (pix.hcount == com_x) || (pix.vcount == com_y);

  always_comb begin
    case (cfg.view)
      video_pkg::view_camera:    out_pixel = cam_444;
      video_pkg::view_mask:      out_pixel = mask ? 12'hfff : 12'h000;
      video_pkg::view_crosshair: out_pixel = on_cross ? 12'h0f0 : cam_444;
      default:                   out_pixel = cam_444;  // unused code
    endcase
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      view <= '0;
    end else begin
      view.pixel  <= out_pixel;
      view.hcount <= pix.hcount;  // coordinates ride along
      view.vcount <= pix.vcount;
      view.valid  <= pix.valid;
    end
  end

endmodule

// ==== design/pixel_threshold.sv ====
module pixel_threshold (
  input  logic               clk_65mhz,
  input  logic               sys_rst,
  input  video_pkg::stream_t pix,
  input  regs_pkg::cfg_t     cfg,
  output video_pkg::stream_t pix_out,
  output logic               mask
);

  video_pkg::nibble_t chan;  // top four bits of the chosen component

  always_comb begin
    case (cfg.channel)
      video_pkg::ch_red:   chan = pix.pixel[15:12];
      video_pkg::ch_green: chan = pix.pixel[10:7];  // green is 6 bits wide
      video_pkg::ch_blue:  chan = pix.pixel[4:1];
      default:             chan = '0;
    endcase
  end

  // stream and mask leave together
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      pix_out <= '0;
      mask    <= 1'b0;
    end else begin
      pix_out <= pix;
      mask    <= pix.valid && (chan >= cfg.lower) && (chan <= cfg.upper);
    end
  end

endmodule

// ==== com/center_of_mass.sv ====
module center_of_mass (
  input  logic               clk_65mhz,
  input  logic               sys_rst,
  input  video_pkg::stream_t pix,
  input  logic               mask,
  output video_pkg::hcount_t com_x,
  output video_pkg::vcount_t com_y,
  output logic               com_update
);

  typedef logic [video_pkg::sum_x_w-1:0] sum_x_t;
  typedef logic [video_pkg::sum_y_w-1:0] sum_y_t;
  typedef logic [video_pkg::count_w-1:0] count_t;

  typedef enum logic [1:0] {st_idle, st_div_x, st_div_y} state_e;

  state_e state;
  sum_x_t sum_x, lat_x;   // running sum and frame-end copy
  sum_y_t sum_y, lat_y;
  count_t count, lat_count;
  logic   div_start, div_done;
  sum_x_t div_dividend, div_quotient;

  // one divider, x first then y
  assign div_dividend = (state == st_div_y) ? sum_x_t'(lat_y) : lat_x;

  always_ff @(posedge clk_65mhz) begin
    if (frame_end_take()) begin
      lat_x     <= sum_x;
      lat_y     <= sum_y;
      lat_count <= count;
    end
  end

  function automatic logic frame_end_take();
    return pix.frame_end && (state == st_idle);  // busy frames are skipped
  endfunction

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state      <= st_idle;
      sum_x      <= '0;
      sum_y      <= '0;
      count      <= '0;
      div_start  <= 1'b0;
      com_x      <= '0;
      com_y      <= '0;
      com_update <= 1'b0;
    end else begin
      div_start  <= 1'b0;
      com_update <= 1'b0;
      if (frame_end_take()) begin
        sum_x <= '0;
        sum_y <= '0;
        count <= '0;
        if (count == '0) begin
          com_update <= 1'b1;  // empty frame, old com stays
        end else begin
          div_start <= 1'b1;
          state     <= st_div_x;
        end
      end else if (pix.valid && mask) begin
        sum_x <= sum_x + sum_x_t'(pix.hcount);
        sum_y <= sum_y + sum_y_t'(pix.vcount);
        count <= count + count_t'(1);
      end
      if (div_done && state == st_div_x) begin
        com_x     <= video_pkg::hcount_t'(div_quotient);
        div_start <= 1'b1;  // y average next
        state     <= st_div_y;
      end else if (div_done && state == st_div_y) begin
        com_y      <= video_pkg::vcount_t'(div_quotient);
        com_update <= 1'b1;
        state      <= st_idle;
      end
    end
  end

  com_divider com_divider_inst (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .start     (div_start),
    .dividend  (div_dividend),
    .divisor   (lat_count),
    .quotient  (div_quotient),
    .done      (div_done)
  );

endmodule

// ==== com/com_divider.sv ====
module com_divider (
  input  logic                          clk_65mhz,
  input  logic                          sys_rst,
  input  logic                          start,
  input  logic [video_pkg::sum_x_w-1:0] dividend,
  input  logic [video_pkg::count_w-1:0] divisor,
  output logic [video_pkg::sum_x_w-1:0] quotient,
  output logic                          done
);

  localparam int cnt_w = $clog2(video_pkg::sum_x_w);

  logic                          busy;
  logic [cnt_w-1:0]              bit_cnt;  // quotient bits still to go
  logic [video_pkg::count_w-1:0] rem, div_q;
  logic [video_pkg::count_w:0]   shifted, diff;

  // bring down the next dividend bit, then try the subtract
  assign shifted = {rem, quotient[video_pkg::sum_x_w-1]};
  assign diff    = shifted - {1'b0, div_q};

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      bit_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (!busy && start) begin
        busy    <= 1'b1;
        bit_cnt <= cnt_w'(video_pkg::sum_x_w - 1);
      end else if (busy) begin
        bit_cnt <= bit_cnt - cnt_w'(1);
        if (bit_cnt == '0) begin
          busy <= 1'b0;
          done <= 1'b1;  // quotient final on this edge
        end
      end
    end
  end

  // quotient shifts in from the bottom while the dividend leaves the top
  always_ff @(posedge clk_65mhz) begin
    if (!busy && start) begin
      quotient <= dividend;
      rem      <= '0;
      div_q    <= divisor;
    end else if (busy) begin
      if (shifted >= {1'b0, div_q}) begin
        rem      <= diff[video_pkg::count_w-1:0];
        quotient <= {quotient[video_pkg::sum_x_w-2:0], 1'b1};
      end else begin
        rem      <= shifted[video_pkg::count_w-1:0];  // restore
        quotient <= {quotient[video_pkg::sum_x_w-2:0], 1'b0};
      end
    end
  end

endmodule

// ==== capture/pixel_capture.sv ====
module pixel_capture (
  input  logic               clk_65mhz,
  input  logic               sys_rst,
  input  logic               cam_pclk,
  input  logic               cam_vsync,
  input  logic               cam_href,
  input  logic [7:0]         cam_data,
  output video_pkg::stream_t pix
);

  logic [1:0] pclk_sync, vsync_sync, href_sync;  // two flops per pin
  logic [7:0] data_meta, data_s;
  logic       pclk_q, vsync_q, href_q;           // previous synced level

  logic pclk_rise, vsync_rise, href_fall;

  logic                 phase;   // 0 waits for high byte, 1 for low byte
  video_pkg::hcount_t   col;
  video_pkg::vcount_t   row;
  logic [7:0]           hi_byte;
  video_pkg::pixel_565_t pix_data;
  video_pkg::hcount_t   pix_col;
  video_pkg::vcount_t   pix_row;
  logic                 pix_valid, pix_end;

  // camera runs on its own clock, bring every pin over
  always_ff @(posedge clk_65mhz) begin
    pclk_sync  <= {pclk_sync[0], cam_pclk};
    vsync_sync <= {vsync_sync[0], cam_vsync};
    href_sync  <= {href_sync[0], cam_href};
    data_meta  <= cam_data;
    data_s     <= data_meta;
    pclk_q     <= pclk_sync[1];
    vsync_q    <= vsync_sync[1];
    href_q     <= href_sync[1];
  end

  assign pclk_rise  = pclk_sync[1] & ~pclk_q;
  assign vsync_rise = vsync_sync[1] & ~vsync_q;
  assign href_fall  = ~href_sync[1] & href_q;  // end of a line

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      phase     <= 1'b0;
      col       <= '0;
      row       <= '0;
      pix_valid <= 1'b0;
      pix_end   <= 1'b0;
    end else begin
      pix_valid <= 1'b0;
      pix_end   <= vsync_rise;  // lone frame_end cycle
      if (vsync_rise) begin
        phase <= 1'b0;
        col   <= '0;
        row   <= '0;
      end else begin
        if (href_fall) begin
          col <= '0;
          if (row != video_pkg::vcount_t'(video_pkg::frame_height - 1))
            row <= row + video_pkg::vcount_t'(1);  // hold at last row
        end
        if (!href_sync[1]) begin
          phase <= 1'b0;  // next line starts on a high byte
        end else if (pclk_rise) begin
          phase <= ~phase;
          if (phase) begin
            pix_valid <= 1'b1;  // low byte completes the pixel
            if (col != video_pkg::hcount_t'(video_pkg::frame_width - 1))
              col <= col + video_pkg::hcount_t'(1);
          end
        end
      end
    end
  end

  // payload, qualified by pix_valid
  always_ff @(posedge clk_65mhz) begin
    if (pclk_rise && href_sync[1]) begin
      if (!phase) begin
        hi_byte <= data_s;
      end else begin
        pix_data <= {hi_byte, data_s};
        pix_col  <= col;
        pix_row  <= row;
      end
    end
  end

  assign pix = '{pixel: pix_data, hcount: pix_col, vcount: pix_row,
                 valid: pix_valid, frame_end: pix_end};

endmodule

// ==== common/regs_pkg.sv ====
package regs_pkg;

  // register byte offsets
  localparam logic [3:0] addr_ctrl   = 4'd0;   // channel 1:0, view 5:4
  localparam logic [3:0] addr_bounds = 4'd4;   // lower 3:0, upper 7:4
  localparam logic [3:0] addr_com    = 4'd8;   // x 10:0, y 25:16, read only
  localparam logic [3:0] addr_frames = 4'd12;  // frame counter 15:0, read only

  typedef struct packed {
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // tracking configuration seen by the datapath
  typedef struct packed {
    video_pkg::channel_e channel;
    video_pkg::view_e    view;
    video_pkg::nibble_t  lower;
    video_pkg::nibble_t  upper;
  } cfg_t;

  localparam cfg_t cfg_reset = '{
    channel: video_pkg::ch_red,
    view:    video_pkg::view_camera,
    lower:   4'h0,
    upper:   4'hf  // full range, every red value passes
  };

endpackage

// ==== common/video_pkg.sv ====
package video_pkg;

  // visible frame at 65 MHz xga timing
  localparam int frame_width  = 1024;
  localparam int frame_height = 768;

  // accumulator widths sized for a full frame of masked pixels
  localparam int count_w = 20;  // up to 1024*768 pixels
  localparam int sum_x_w = 31;  // 11-bit columns times count
  localparam int sum_y_w = 30;  // 10-bit rows times count

  typedef logic [15:0] pixel_565_t;  // camera rgb565
  typedef logic [11:0] pixel_444_t;  // screen rgb444
  typedef logic [10:0] hcount_t;     // column index
  typedef logic [9:0]  vcount_t;     // row index
  typedef logic [3:0]  nibble_t;     // top bits of one channel

  // camera side pixel stream, no back-pressure
  typedef struct packed {
    pixel_565_t pixel;
    hcount_t    hcount;
    vcount_t    vcount;
    logic       valid;      // one cycle per pixel
    logic       frame_end;  // vsync rising edge, valid stays low
  } stream_t;

  // screen side pixel stream
  typedef struct packed {
    pixel_444_t pixel;
    hcount_t    hcount;
    vcount_t    vcount;
    logic       valid;
  } view_t;

  typedef enum logic [1:0] {
    ch_red   = 2'd0,
    ch_green = 2'd1,
    ch_blue  = 2'd2
  } channel_e;

  typedef enum logic [1:0] {
    view_camera    = 2'd0,  // 444 camera image
    view_mask      = 2'd1,  // black/white threshold mask
    view_crosshair = 2'd2   // camera image plus green crosshair on com
  } view_e;

endpackage
